/* src/qspi_pkg.sv */
package qspi_pkg;

    typedef logic [23:0] flash_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [1:0]  bus_size_t;
    typedef logic [1:0]  lane_width_t;
    typedef logic [2:0]  read_mode_t;

    localparam bus_size_t SIZE_1B = 2'd0;
    localparam bus_size_t SIZE_2B = 2'd1;
    localparam bus_size_t SIZE_4B = 2'd2; // code 3 invalid

    localparam lane_width_t LANE_X1 = 2'd0;
    localparam lane_width_t LANE_X2 = 2'd1;
    localparam lane_width_t LANE_X4 = 2'd2;

    localparam int DMY_CNT_W = 4;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_GAP,
        SEQ_CMD,
        SEQ_ADDR,
        SEQ_DMY,
        SEQ_DATA,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_TX,
        ENG_RX,
        ENG_DMY
    } eng_state_t;

    // mode digits are cmd, addr and data widths; mode 7 falls back to 1-1-1
    function automatic lane_width_t mode_cmd_width(read_mode_t mode);
        case (mode)
            3'd5:    return LANE_X2;
            3'd6:    return LANE_X4;
            default: return LANE_X1;
        endcase
    endfunction

    function automatic lane_width_t mode_addr_width(read_mode_t mode);
        case (mode)
            3'd3, 3'd5: return LANE_X2;
            3'd4, 3'd6: return LANE_X4;
            default:    return LANE_X1;
        endcase
    endfunction

    function automatic lane_width_t mode_data_width(read_mode_t mode);
        case (mode)
            3'd1, 3'd3, 3'd5: return LANE_X2;
            3'd2, 3'd4, 3'd6: return LANE_X4;
            default:          return LANE_X1;
        endcase
    endfunction

    function automatic logic [2:0] size_bytes(bus_size_t size);
        case (size)
            SIZE_2B: return 3'd2;
            SIZE_4B: return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

endpackage

/* src/read_cmd_if.sv */
interface read_cmd_if import qspi_pkg::*; ();
    logic        start; // one cycle, sequencer idle
    flash_addr_t addr;
    bus_size_t   size;
    logic        done;  // one cycle, ends the read
    bus_data_t   rdata;

    modport port (
        output start, addr, size,
        input  done, rdata
    );

    modport seq (
        input  start, addr, size,
        output done, rdata
    );
endinterface

/* src/shift_if.sv */
interface shift_if import qspi_pkg::*; ();
    lane_width_t width;
    logic        tx_req;
    logic [7:0]  tx_byte;
    logic        rx_req;
    logic        dmy_req;
    logic        dmy_dir;     // 1 drives the pattern
    logic [3:0]  dmy_pattern;
    logic        tx_done;
    logic        rx_done;
    logic        dmy_done;
    logic [7:0]  rx_byte;     // valid with rx_done

    modport seq (
        output width, tx_req, tx_byte, rx_req, dmy_req, dmy_dir, dmy_pattern,
        input  tx_done, rx_done, dmy_done, rx_byte
    );

    modport eng (
        input  width, tx_req, tx_byte, rx_req, dmy_req, dmy_dir, dmy_pattern,
        output tx_done, rx_done, dmy_done, rx_byte
    );
endinterface

/* src/qspi_bus_port.sv */
module qspi_bus_port
    import qspi_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        req,
    input  flash_addr_t addr,
    input  bus_size_t   size,
    input  logic        wr,
    output logic        ack,
    output bus_data_t   rdata,
    output logic        fault,
    read_cmd_if.port    cmd
);
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_CHECK,
        PORT_WAIT,
        PORT_ACK
    } port_state_t;

    port_state_t state;
    logic        bad;
    logic        bad_q;

    // only aligned reads reach the flash
    assign bad = wr
              || !(size inside {SIZE_1B, SIZE_2B, SIZE_4B})
              || (addr[0] && size != SIZE_1B)
              || (size == SIZE_4B && addr[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= PORT_IDLE;
            cmd.start <= 1'b0;
            ack       <= 1'b0;
            fault     <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (req)
                        state <= PORT_CHECK;
                end
                PORT_CHECK: begin
                    if (bad_q) begin
                        ack   <= 1'b1;
                        fault <= 1'b1;
                        state <= PORT_ACK;
                    end else begin
                        cmd.start <= 1'b1;
                        state     <= PORT_WAIT;
                    end
                end
                PORT_WAIT: begin
                    if (cmd.done) begin
                        ack   <= 1'b1;
                        state <= PORT_ACK;
                    end
                end
                default: begin
                    if (!req) begin // four-phase close
                        ack   <= 1'b0;
                        fault <= 1'b0;
                        state <= PORT_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && req) begin
            cmd.addr <= addr;
            cmd.size <= size;
            bad_q    <= bad;
        end
        if (state == PORT_CHECK && bad_q)
            rdata <= '0;
        else if (state == PORT_WAIT && cmd.done)
            rdata <= cmd.rdata;
    end

    assert property (@(posedge clk) disable iff (!rstn) $rose(ack) |-> $past(req))
        else $error("ack rose without req");

endmodule

/* src/qspi_read_sequencer.sv */
module qspi_read_sequencer
    import qspi_pkg::*;
#(
    parameter int CSB_GAP = 2
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  read_mode_t           mode,
    input  logic [7:0]           cmd_octet,
    input  logic [DMY_CNT_W-1:0] dmy_cnt,
    input  logic                 dmy_dir,
    input  logic [3:0]           dmy_pattern,
    output logic                 qspi_csb,
    read_cmd_if.seq              cmd,
    shift_if.seq                 sh
);
    localparam int CNT_W = (CSB_GAP > 15) ? $clog2(CSB_GAP + 1) : DMY_CNT_W;

    seq_state_t       state;
    logic [CNT_W-1:0] cnt;
    logic             kick;      // next shift request goes out
    logic [7:0]       addr_byte;
    logic [CNT_W-1:0] last_byte;

    assign last_byte = CNT_W'(size_bytes(cmd.size) - 3'd1);

    always_comb begin
        case (cnt[1:0])
            2'd2:    addr_byte = cmd.addr[23:16];
            2'd1:    addr_byte = cmd.addr[15:8];
            default: addr_byte = cmd.addr[7:0];
        endcase
    end

    always_comb begin
        case (state)
            SEQ_CMD:           sh.width = mode_cmd_width(mode);
            SEQ_ADDR, SEQ_DMY: sh.width = mode_addr_width(mode); // dummy at addr width
            default:           sh.width = mode_data_width(mode);
        endcase
    end

    assign sh.tx_req      = kick && (state == SEQ_CMD || state == SEQ_ADDR);
    assign sh.dmy_req     = kick && (state == SEQ_DMY);
    assign sh.rx_req      = kick && (state == SEQ_DATA);
    assign sh.tx_byte     = (state == SEQ_CMD) ? cmd_octet : addr_byte;
    assign sh.dmy_dir     = dmy_dir;
    assign sh.dmy_pattern = dmy_pattern;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= SEQ_IDLE;
            cnt      <= '0;
            kick     <= 1'b0;
            qspi_csb <= 1'b1;
            cmd.done <= 1'b0;
        end else begin
            kick     <= 1'b0;
            cmd.done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (cmd.start) begin
                        state <= SEQ_GAP;
                        cnt   <= CNT_W'(CSB_GAP - 1);
                    end
                end
                SEQ_GAP: begin
                    if (!qspi_csb) begin
                        state <= SEQ_CMD; // one cycle after csb fell
                        kick  <= 1'b1;
                    end else if (cnt == '0) begin
                        qspi_csb <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                SEQ_CMD: begin
                    if (sh.tx_done) begin
                        state <= SEQ_ADDR;
                        cnt   <= CNT_W'(2); // msb first
                        kick  <= 1'b1;
                    end
                end
                SEQ_ADDR: begin
                    if (sh.tx_done) begin
                        kick <= 1'b1;
                        if (cnt != '0) begin
                            cnt <= cnt - 1'b1;
                        end else if (dmy_cnt != '0) begin
                            state <= SEQ_DMY;
                            cnt   <= CNT_W'(dmy_cnt);
                        end else begin
                            state <= SEQ_DATA;
                            cnt   <= '0;
                        end
                    end
                end
                SEQ_DMY: begin
                    if (sh.dmy_done) begin
                        kick <= 1'b1;
                        if (cnt == CNT_W'(1)) begin
                            state <= SEQ_DATA;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end
                end
                SEQ_DATA: begin
                    if (sh.rx_done) begin
                        if (cnt == last_byte) begin
                            state    <= SEQ_DONE;
                            qspi_csb <= 1'b1;
                        end else begin
                            cnt  <= cnt + 1'b1;
                            kick <= 1'b1;
                        end
                    end
                end
                SEQ_DONE: begin
                    state    <= SEQ_IDLE;
                    cmd.done <= 1'b1;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // byte k lands at bits 8k upward
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && cmd.start)
            cmd.rdata <= '0;
        else if (state == SEQ_DATA && sh.rx_done)
            cmd.rdata[{cnt[1:0], 3'b000} +: 8] <= sh.rx_byte;
    end

    assert property (@(posedge clk) disable iff (!rstn)
        cmd.start |-> (state == SEQ_IDLE))
        else $error("start while a read is in flight");

endmodule

/* src/qspi_shift_engine.sv */
module qspi_shift_engine
    import qspi_pkg::*;
#(
    parameter bit SCLK_IDLE = 1'b0
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic [3:0] qspi_miso,
    output logic       qspi_sclk,
    output logic [3:0] qspi_dir,
    output logic [3:0] qspi_mosi,
    shift_if.eng       sh
);
    eng_state_t state;
    logic [3:0] cnt;       // half periods left
    logic [7:0] sr;        // shared by tx and rx
    logic [7:0] shifted;
    logic [3:0] tx_bits;
    logic [3:0] lane_mask;
    logic [3:0] last_cnt;

    always_comb begin
        case (sh.width)
            LANE_X2: begin
                lane_mask = 4'b0011;
                last_cnt  = 4'd7;
                tx_bits   = {2'b00, sr[7:6]};
                shifted   = {sr[5:0], qspi_miso[1:0]};
            end
            LANE_X4: begin
                lane_mask = 4'b1111;
                last_cnt  = 4'd3;
                tx_bits   = sr[7:4];
                shifted   = {sr[3:0], qspi_miso};
            end
            default: begin
                lane_mask = 4'b0001;
                last_cnt  = 4'd15;
                tx_bits   = {3'b000, sr[7]};
                shifted   = {sr[6:0], qspi_miso[1]}; // x1 reads back on lane 1
            end
        endcase
    end

    assign qspi_sclk   = (state != ENG_IDLE) ? ~cnt[0] : SCLK_IDLE;
    assign sh.tx_done  = (state == ENG_TX) && (cnt == 4'd0);
    assign sh.rx_done  = (state == ENG_RX) && (cnt == 4'd0);
    assign sh.dmy_done = (state == ENG_DMY) && (cnt == 4'd0);
    assign sh.rx_byte  = shifted; // last group straight from the pins

    always_comb begin
        qspi_dir  = 4'b0000;
        qspi_mosi = 4'b0000;
        if (state == ENG_TX) begin
            qspi_dir  = lane_mask;
            qspi_mosi = tx_bits;
        end else if (state == ENG_DMY && sh.dmy_dir) begin
            qspi_dir  = lane_mask;
            qspi_mosi = sh.dmy_pattern & lane_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ENG_IDLE;
            cnt   <= 4'd0;
        end else if (cnt == 4'd0) begin
            if (sh.tx_req) begin
                state <= ENG_TX;
                cnt   <= last_cnt;
            end else if (sh.rx_req) begin
                state <= ENG_RX;
                cnt   <= last_cnt;
            end else if (sh.dmy_req) begin
                state <= ENG_DMY;
                cnt   <= 4'd1;
            end else begin
                state <= ENG_IDLE;
            end
        end else begin
            cnt <= cnt - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt == 4'd0 && sh.tx_req)
            sr <= sh.tx_byte;
        else if ((state == ENG_TX || state == ENG_RX) && !cnt[0] && cnt != 4'd0)
            sr <= shifted; // end of a high phase
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (sh.tx_req || sh.rx_req || sh.dmy_req) |-> (cnt == 4'd0))
        else $error("shift request while engine busy");

endmodule

/* src/qspi_read_top.sv */
module qspi_read_top
    import qspi_pkg::*;
#(
    parameter bit SCLK_IDLE = 1'b0,
    parameter int CSB_GAP   = 2
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req,
    input  flash_addr_t          addr,
    input  bus_size_t            size,
    input  logic                 wr,
    output logic                 ack,
    output bus_data_t            rdata,
    output logic                 fault,
    input  read_mode_t           mode,
    input  logic [7:0]           cmd_octet,
    input  logic [DMY_CNT_W-1:0] dmy_cnt,
    input  logic                 dmy_dir,
    input  logic [3:0]           dmy_pattern,
    output logic                 qspi_csb,
    output logic                 qspi_sclk,
    output logic [3:0]           qspi_dir,
    output logic [3:0]           qspi_mosi,
    input  logic [3:0]           qspi_miso
);
    read_cmd_if cmd_bus ();
    shift_if    sh_bus ();

    qspi_bus_port qspi_bus_port (
        .clk   (clk),
        .rstn  (rstn),
        .req   (req),
        .addr  (addr),
        .size  (size),
        .wr    (wr),
        .ack   (ack),
        .rdata (rdata),
        .fault (fault),
        .cmd   (cmd_bus.port)
    );

    qspi_read_sequencer #(
        .CSB_GAP(CSB_GAP)
    ) qspi_read_sequencer (
        .clk         (clk),
        .rstn        (rstn),
        .mode        (mode),
        .cmd_octet   (cmd_octet),
        .dmy_cnt     (dmy_cnt),
        .dmy_dir     (dmy_dir),
        .dmy_pattern (dmy_pattern),
        .qspi_csb    (qspi_csb),
        .cmd         (cmd_bus.seq),
        .sh          (sh_bus.seq)
    );

    qspi_shift_engine #(
        .SCLK_IDLE(SCLK_IDLE)
    ) qspi_shift_engine (
        .clk       (clk),
        .rstn      (rstn),
        .qspi_miso (qspi_miso),
        .qspi_sclk (qspi_sclk),
        .qspi_dir  (qspi_dir),
        .qspi_mosi (qspi_mosi),
        .sh        (sh_bus.eng)
    );

endmodule

/* sim/flash_model.sv */
module flash_model
    import qspi_pkg::*;
(
    input  logic                 qspi_csb,
    input  logic                 qspi_sclk,
    input  logic [3:0]           qspi_dir,
    input  logic [3:0]           qspi_mosi,
    output logic [3:0]           qspi_miso,
    input  read_mode_t           mode,
    input  logic [DMY_CNT_W-1:0] dmy_cnt,
    input  logic                 dmy_dir,
    input  logic [3:0]           dmy_pattern,
    output logic [7:0]           seen_cmd,
    output flash_addr_t          seen_addr,
    output int                   frames,
    output int                   errors
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        prev_sclk;
    logic        prev_csb;
    logic [31:0] in_sr;      // cmd byte then address
    int          rises;
    int          cmd_edges;
    int          pre_edges;  // rising edges before the data phase

    // bits per serial clock for one digit of the mode name
    function automatic int digit_bits(read_mode_t m, int digit);
        case (m)
            3'd1:    return (digit == 2) ? 2 : 1;
            3'd2:    return (digit == 2) ? 4 : 1;
            3'd3:    return (digit == 0) ? 1 : 2;
            3'd4:    return (digit == 0) ? 1 : 4;
            3'd5:    return 2;
            3'd6:    return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic [3:0] lanes(int w);
        return (w == 4) ? 4'hf : (w == 2) ? 4'h3 : 4'h1;
    endfunction

    task automatic fail_check(string msg);
        $display("CHECK FAILED at %0t: flash model, %s", $time, msg);
        errors++;
    endtask

    task automatic sample_rise();
        int w;
        int addr_edges;
        cmd_edges  = 8 / digit_bits(mode, 0);
        addr_edges = 24 / digit_bits(mode, 1);
        pre_edges  = cmd_edges + addr_edges + int'(dmy_cnt);
        w = (rises < cmd_edges) ? digit_bits(mode, 0) : digit_bits(mode, 1);
        if (rises < cmd_edges + addr_edges) begin
            in_sr = (in_sr << w) | {28'd0, qspi_mosi & lanes(w)};
            if (rises == cmd_edges + addr_edges - 1) begin
                seen_cmd  = in_sr[31:24];
                seen_addr = in_sr[23:0];
            end
        end else if (rises < pre_edges) begin
            if (dmy_dir) begin
                assert (qspi_dir == lanes(w) && (qspi_mosi & lanes(w)) == (dmy_pattern & lanes(w)))
                    else fail_check("dummy lanes do not carry the pattern");
            end else begin
                assert (qspi_dir == 4'h0) else fail_check("lanes driven in released dummy");
            end
        end else begin
            assert (qspi_dir == 4'h0) else fail_check("lanes driven in data phase");
        end
        rises++;
    endtask

    // next data group goes out after each falling edge
    task automatic drive_fall();
        int         dw;
        int         g;
        logic [7:0] b;
        logic [3:0] grp;
        dw = digit_bits(mode, 2);
        g  = rises - pre_edges;
        if (g < 0) begin
            qspi_miso = 4'h0;
        end else begin
            b   = 8'(seen_addr + 24'(g / (8 / dw))) ^ 8'ha5;
            grp = 4'(b >> (8 - dw * (g % (8 / dw) + 1))) & lanes(dw);
            qspi_miso = (dw == 1) ? {2'b00, grp[0], 1'b0} : grp; // x1 answers on lane 1
        end
    endtask

    initial begin
        qspi_miso = 4'h0;
        seen_cmd  = 8'h00;
        seen_addr = '0;
        frames    = 0;
        errors    = 0;
        prev_sclk = 1'b0;
        prev_csb  = 1'b1;
        in_sr     = '0;
        rises     = 0;
        pre_edges = 0;
    end

    always begin
        @(qspi_sclk or qspi_csb);
        #1;
        if (prev_csb === 1'b1 && qspi_csb === 1'b0) begin
            rises = 0;
            in_sr = '0;
        end
        if (prev_csb === 1'b0 && qspi_csb === 1'b1) begin
            frames++;
            qspi_miso = 4'h0;
        end
        if (qspi_csb === 1'b0 && prev_sclk === 1'b0 && qspi_sclk === 1'b1)
            sample_rise();
        else if (qspi_csb === 1'b0 && prev_sclk === 1'b1 && qspi_sclk === 1'b0)
            drive_fall();
        prev_csb  = qspi_csb;
        prev_sclk = qspi_sclk;
    end

endmodule

/* sim/tb_top.sv */
module tb_top
    import qspi_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam bit SCLK_IDLE       = 1'b0;
    localparam int CSB_GAP         = 2;
    localparam int CLK_PERIOD      = 20;
    localparam int RAND_READS      = 8;
    localparam int NUM_READS       = 1 + 1 + RAND_READS + 3 + 1;
    localparam int MAX_READ_CYCLES = 160; // 1-1-1, 15 dummy pulses, 4 bytes

    logic                 clk;
    logic                 rstn;
    logic                 req;
    flash_addr_t          addr;
    bus_size_t            size;
    logic                 wr;
    logic                 ack;
    bus_data_t            rdata;
    logic                 fault;
    read_mode_t           mode;
    logic [7:0]           cmd_octet;
    logic [DMY_CNT_W-1:0] dmy_cnt;
    logic                 dmy_dir;
    logic [3:0]           dmy_pattern;
    logic                 qspi_csb;
    logic                 qspi_sclk;
    logic [3:0]           qspi_dir;
    logic [3:0]           qspi_mosi;
    logic [3:0]           qspi_miso;
    logic [7:0]           seen_cmd;
    flash_addr_t          seen_addr;
    int                   frames;
    int                   flash_errors;
    int                   errors = 0;
    int                   tests = 0;
    int                   csb_high_cycles;
    int                   errs_before;
    flash_addr_t          a;
    logic [15:0]          lfsr_state = 16'd22056;

    qspi_read_top #(.SCLK_IDLE(SCLK_IDLE), .CSB_GAP(CSB_GAP)) DUT (.*);

    flash_model flash (.*, .errors(flash_errors));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 16, 14, 13, 11
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic bus_data_t expected_word(flash_addr_t base, int nbytes);
        bus_data_t w;
        w = '0;
        for (int k = 0; k < nbytes; k++)
            w[8*k +: 8] = 8'(base + 24'(k)) ^ 8'ha5;
        return w;
    endfunction

    function automatic void note_error(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic bus_read(input flash_addr_t ra, input bus_size_t rs, input logic rw,
                            input int hold, output bus_data_t data, output logic flt,
                            output int cycles);
        addr   = ra;
        size   = rs;
        wr     = rw;
        req    = 1'b1;
        cycles = 0;
        while (ack !== 1'b1 && cycles < 2 * MAX_READ_CYCLES) begin
            step();
            cycles++;
        end
        if (ack !== 1'b1) begin
            $display("no ack from the DUT within %0d cycles", cycles);
            errors++;
        end
        data = rdata;
        flt  = fault;
        repeat (hold) step(); // master stalls the close
        req = 1'b0;
        for (int i = 0; i < 4 && ack === 1'b1; i++)
            step();
        assert (ack === 1'b0) else note_error("ack still high after req fell");
        step();
    endtask

    task automatic check_read(input flash_addr_t ra, input bus_size_t rs, input read_mode_t m,
                              input logic [7:0] c, input logic [3:0] dc, input logic dd,
                              input int hold);
        bus_data_t data;
        logic      flt;
        int        cycles;
        int        frames_before;
        int        nbytes;
        nbytes        = (rs == SIZE_4B) ? 4 : (rs == SIZE_2B) ? 2 : 1;
        mode          = m;
        cmd_octet     = c;
        dmy_cnt       = dc;
        dmy_dir       = dd;
        frames_before = frames;
        bus_read(ra, rs, 1'b0, hold, data, flt, cycles);
        assert (!flt) else note_error($sformatf("fault on read at %06h", ra));
        assert (data == expected_word(ra, nbytes))
            else note_error($sformatf("rdata %08h at %06h mode %0d, expected %08h",
                                      data, ra, m, expected_word(ra, nbytes)));
        assert (seen_cmd == c && seen_addr == ra)
            else note_error($sformatf("flash saw cmd %02h addr %06h", seen_cmd, seen_addr));
        assert (frames == frames_before + 1)
            else note_error($sformatf("%0d flash frames for one read", frames - frames_before));
    endtask

    task automatic check_fault(input flash_addr_t ra, input bus_size_t rs, input logic rw);
        bus_data_t data;
        logic      flt;
        int        cycles;
        int        frames_before;
        frames_before = frames;
        bus_read(ra, rs, rw, 0, data, flt, cycles);
        assert (flt) else note_error($sformatf("no fault at %06h size %0d wr %0b", ra, rs, rw));
        assert (cycles == 2) else note_error($sformatf("fault ack after %0d cycles", cycles));
        assert (frames == frames_before && qspi_csb)
            else note_error("chip select moved on a faulting request");
    endtask

    task automatic report_test(string name);
        tests++;
        if (errors + flash_errors == errs_before)
            $display("test %0d, %s: passed", tests, name);
        else
            $display("test %0d, %s: failed", tests, name);
        errs_before = errors + flash_errors;
    endtask

    // handshake and framing rules
    assert property (@(posedge clk) disable iff (!rstn) $rose(ack) |-> $past(req))
        else note_error("ack rose while req was low");
    assert property (@(posedge clk) disable iff (!rstn) $fell(ack) |-> !$past(req))
        else note_error("ack fell before req was released");
    assert property (@(posedge clk) disable iff (!rstn) ack |-> qspi_csb)
        else note_error("chip select low while ack high");
    assert property (@(posedge clk) disable iff (!rstn) qspi_csb |-> (qspi_sclk == SCLK_IDLE))
        else note_error("serial clock not idle while chip select high");

    always @(posedge clk) begin
        if (!rstn) begin
            csb_high_cycles <= 0;
        end else if (qspi_csb) begin
            csb_high_cycles <= csb_high_cycles + 1;
        end else begin
            if (csb_high_cycles != 0)
                assert (csb_high_cycles >= CSB_GAP) else note_error("chip select gap too short");
            csb_high_cycles <= 0;
        end
    end

    initial begin
        #(NUM_READS * MAX_READ_CYCLES * 2 * CLK_PERIOD);
        $display("run hung: watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rstn        = 1'b0;
        req         = 1'b0;
        addr        = '0;
        size        = SIZE_1B;
        wr          = 1'b0;
        mode        = 3'd0;
        cmd_octet   = 8'h03;
        dmy_cnt     = '0;
        dmy_dir     = 1'b0;
        dmy_pattern = 4'h0;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        assert (!ack && !fault && qspi_csb && qspi_sclk == SCLK_IDLE && qspi_dir == 4'h0)
            else note_error("outputs not at their reset values");
        errs_before = errors + flash_errors;

        a = 24'(rand_bits(24));
        check_read(a, SIZE_1B, 3'd0, 8'h03, 4'd0, 1'b0, 0);
        report_test("single byte, mode 1-1-1");

        a           = {22'(rand_bits(22)), 2'b00};
        dmy_pattern = 4'(rand_bits(4));
        check_read(a, SIZE_4B, 3'd6, 8'heb, 4'd4, 1'b1, 0);
        report_test("four bytes, mode 4-4-4, driven dummy");

        for (int i = 0; i < RAND_READS; i++) begin
            a = {23'(rand_bits(23)), 1'b0};
            check_read(a, SIZE_2B, 3'(1 + rand_bits(8) % 5), 8'hbb, 4'(rand_bits(4)), 1'b0, 0);
        end
        report_test("two bytes, random modes and dummy counts");

        check_fault({23'(rand_bits(23)), 1'b1}, SIZE_2B, 1'b0);
        check_fault({22'(rand_bits(22)), 2'b10}, SIZE_4B, 1'b0);
        check_fault({22'(rand_bits(22)), 2'b00}, SIZE_1B, 1'b1);
        report_test("faults");

        a = {23'(rand_bits(23)), 1'b0};
        check_read(a, SIZE_2B, 3'd2, 8'h6b, 4'd8, 1'b0, 10);
        report_test("req held after ack");

        $display("%0d tests run, %0d errors", tests, errors + flash_errors);
        if (errors + flash_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb.f */
src/qspi_pkg.sv
src/read_cmd_if.sv
src/shift_if.sv
src/qspi_bus_port.sv
src/qspi_read_sequencer.sv
src/qspi_shift_engine.sv
src/qspi_read_top.sv
sim/flash_model.sv
sim/tb_top.sv

/* Makefile */
TOP = tb_top
RTL = src/qspi_pkg.sv src/read_cmd_if.sv src/shift_if.sv src/qspi_bus_port.sv \
      src/qspi_read_sequencer.sv src/qspi_shift_engine.sv src/qspi_read_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall $(RTL) --top-module qspi_read_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "NO ERRORS" sim.log
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log
